// ==== hw/fifo_config.svh ====
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// RAM address bits
// Depth is 2**FIFO_ADDR_WIDTH words
`define FIFO_ADDR_WIDTH 4

// Width of one stored word
`define FIFO_DATA_WIDTH 16

// Flops in each clock domain crossing synchronizer
// Two is the usual minimum for metastability settling
`define FIFO_SYNC_STAGES 2

// Number of words the RAM holds
`define FIFO_DEPTH (1 << `FIFO_ADDR_WIDTH)

`endif

// ==== hw/fifo_pkg.sv ====
`include "fifo_config.svh"

package fifo_pkg;

   // Binary pointer with one extra bit above the address
   // Same addr with a different wrap means full, equal pointers mean empty
   typedef struct packed {
      logic                        wrap;  // Toggles each pass through the RAM
      logic [`FIFO_ADDR_WIDTH-1:0] addr;  // RAM word address
   } fifo_ptr_t;

   typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_gray_t;   // Pointer in Gray code
   typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_count_t;  // 0 up to and including depth
   typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;   // One FIFO word

   // Binary to Gray, one bit changes per increment
   function automatic fifo_gray_t bin2gray(input fifo_ptr_t ptr);
      logic [`FIFO_ADDR_WIDTH:0] bin;
      bin = ptr;
      return bin ^ (bin >> 1);
   endfunction

   // Gray back to binary
   // Each bit is the XOR of all Gray bits at and above it
   function automatic fifo_ptr_t gray2bin(input fifo_gray_t gray);
      logic [`FIFO_ADDR_WIDTH:0] bin;
      bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];  // MSB passes straight
      for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--)
      begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return fifo_ptr_t'(bin);
   endfunction

endpackage

// ==== hw/gray_sync.sv ====
`timescale 1ns/1ps
`include "fifo_config.svh"

// Brings a Gray pointer into the clk domain
// Only Gray code may cross here since at most one bit is in flight
module gray_sync (
   input  logic                 clk,
   input  logic                 aclr,
   input  fifo_pkg::fifo_gray_t gray_in,  // Launched from the other clock domain
   output fifo_pkg::fifo_ptr_t  ptr_out   // Binary pointer local to clk
);

   fifo_pkg::fifo_gray_t stage [`FIFO_SYNC_STAGES];  // stage[0] may go metastable

   always_ff @(posedge clk or posedge aclr)
   begin
      if (aclr)
      begin
         for (int i = 0; i < `FIFO_SYNC_STAGES; i++)
         begin
            stage[i] <= '0;
         end
         ptr_out <= '0;
      end
      else
      begin
         stage[0] <= gray_in;
         for (int i = 1; i < `FIFO_SYNC_STAGES; i++)
         begin
            stage[i] <= stage[i-1];  // Shift toward the settled end
         end
         // Decode after the last flop, register to keep the path short
         ptr_out <= fifo_pkg::gray2bin(stage[`FIFO_SYNC_STAGES-1]);
      end
   end

endmodule

// ==== hw/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_config.svh"

// Write domain control
// Owns the write pointer and the wrclk status flags
module fifo_wr_ctrl (
   input  logic                        wrclk,
   input  logic                        aclr,
   input  logic                        wrreq,
   input  fifo_pkg::fifo_ptr_t         rd_ptr_wr,  // Read pointer seen from wrclk
   output logic                        wr_en,      // RAM write strobe
   output logic [`FIFO_ADDR_WIDTH-1:0] wr_addr,
   output fifo_pkg::fifo_gray_t        wr_gray,    // Goes to the read domain
   output logic                        wrfull,
   output fifo_pkg::fifo_count_t       wrusedw
);

   fifo_pkg::fifo_ptr_t wr_ptr;       // Next location to write
   fifo_pkg::fifo_ptr_t wr_ptr_next;
   logic                full_now;     // Full against the synchronized read pointer
   logic                full_next;    // Full once this edge's write lands

   // Same address on the other lap of the RAM
   assign full_now = (wr_ptr.addr == rd_ptr_wr.addr) && (wr_ptr.wrap != rd_ptr_wr.wrap);

   always_comb
   begin
      wr_en       = wrreq && !full_now;  // Writes at full are dropped
      wr_ptr_next = wr_ptr;
      if (wr_en)
      begin
         wr_ptr_next = fifo_pkg::fifo_ptr_t'(wr_ptr + 1'b1);  // Carry runs into wrap
      end
   end

   assign full_next = (wr_ptr_next.addr == rd_ptr_wr.addr)
                   && (wr_ptr_next.wrap != rd_ptr_wr.wrap);

   assign wr_addr = wr_ptr.addr;  // RAM takes the current pointer

   always_ff @(posedge wrclk or posedge aclr)
   begin
      if (aclr)
      begin
         wr_ptr  <= '0;
         wr_gray <= '0;
         wrfull  <= 1'b0;
         wrusedw <= '0;
      end
      else
      begin
         wr_ptr  <= wr_ptr_next;
         // Data is in the RAM at this same edge, so the Gray pointer may move now
         wr_gray <= fifo_pkg::bin2gray(wr_ptr_next);
         wrfull  <= full_next;
         // Modulo subtraction handles the wrap
         wrusedw <= fifo_pkg::fifo_count_t'(wr_ptr_next) - fifo_pkg::fifo_count_t'(rd_ptr_wr);
      end
   end

endmodule

// ==== hw/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_config.svh"

// Read domain control
// Owns the read pointer, the RAM read address and the rdclk status flags
module fifo_rd_ctrl (
   input  logic                        rdclk,
   input  logic                        aclr,
   input  logic                        rdreq,
   input  fifo_pkg::fifo_ptr_t         wr_ptr_rd,  // Write pointer seen from rdclk
   output logic                        rd_en,      // Accepted read, loads q
   output logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
   output fifo_pkg::fifo_gray_t        rd_gray,    // Goes to the write domain
   output logic                        rdempty,
   output fifo_pkg::fifo_count_t       rdusedw,
   output logic                        rdvalid
);

   fifo_pkg::fifo_ptr_t rd_ptr;       // Next location to read
   fifo_pkg::fifo_ptr_t rd_ptr_next;
   logic                has_data;

   // Any difference means at least one written word is visible here
   assign has_data = (rd_ptr != wr_ptr_rd);

   always_comb
   begin
      rd_en       = rdreq && has_data;  // Reads at empty are dropped
      rd_ptr_next = rd_ptr;
      if (rd_en)
      begin
         rd_ptr_next = fifo_pkg::fifo_ptr_t'(rd_ptr + 1'b1);
      end
   end

   // RAM registers this, so after the edge its output is the word at rd_ptr
   assign rd_addr = rd_ptr_next.addr;

   always_ff @(posedge rdclk or posedge aclr)
   begin
      if (aclr)
      begin
         rd_ptr  <= '0;
         rd_gray <= '0;
         rdempty <= 1'b1;  // Nothing written yet
         rdusedw <= '0;
         rdvalid <= 1'b0;
      end
      else
      begin
         rd_ptr  <= rd_ptr_next;
         // q has already captured the word, so the slot can be released
         rd_gray <= fifo_pkg::bin2gray(rd_ptr_next);
         rdempty <= (wr_ptr_rd == rd_ptr_next);
         rdusedw <= fifo_pkg::fifo_count_t'(wr_ptr_rd) - fifo_pkg::fifo_count_t'(rd_ptr_next);
         rdvalid <= rd_en;  // Lines up with the q load
      end
   end

endmodule

// ==== hw/fifo_ram.sv ====
`timescale 1ns/1ps
`include "fifo_config.svh"

// Simple dual-port storage
// Write on wrclk, registered read address and a fabric output register on rdclk
module fifo_ram (
   input  logic                        wrclk,
   input  logic                        rdclk,
   input  logic                        wr_en,
   input  logic [`FIFO_ADDR_WIDTH-1:0] wr_addr,
   input  fifo_pkg::fifo_data_t        data,
   input  logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
   input  logic                        rd_en,
   output fifo_pkg::fifo_data_t        q
);

   fifo_pkg::fifo_data_t        mem [`FIFO_DEPTH];
   logic [`FIFO_ADDR_WIDTH-1:0] rd_addr_q;  // Loaded every cycle, no enable
   fifo_pkg::fifo_data_t        ram_q;      // Word at the current read pointer

   always_ff @(posedge wrclk)
   begin
      if (wr_en)
         mem[wr_addr] <= data;
   end

   always_ff @(posedge rdclk)
   begin
      rd_addr_q <= rd_addr;
   end

   // A word written after the last read still flows through here
   assign ram_q = mem[rd_addr_q];

   // Output register, holds q until the next accepted read
   always_ff @(posedge rdclk)
   begin
      if (rd_en)
         q <= ram_q;
   end

endmodule

// ==== hw/lite_fifo.sv ====
`timescale 1ns/1ps
`include "fifo_config.svh"

// Dual-clock FIFO top
// Pointers cross as Gray code, one synchronizer per direction
module lite_fifo (
   input  logic                  wrclk,
   input  logic                  rdclk,
   input  logic                  aclr,     // Clears both domains
   input  logic                  wrreq,
   input  fifo_pkg::fifo_data_t  data,
   input  logic                  rdreq,
   output logic                  wrfull,
   output fifo_pkg::fifo_count_t wrusedw,
   output logic                  rdempty,
   output fifo_pkg::fifo_count_t rdusedw,
   output logic                  rdvalid,
   output fifo_pkg::fifo_data_t  q
);

   logic                        wr_en;
   logic [`FIFO_ADDR_WIDTH-1:0] wr_addr;
   fifo_pkg::fifo_gray_t        wr_gray;    // wrclk domain
   fifo_pkg::fifo_ptr_t         wr_ptr_rd;  // rdclk domain
   logic                        rd_en;
   logic [`FIFO_ADDR_WIDTH-1:0] rd_addr;
   fifo_pkg::fifo_gray_t        rd_gray;    // rdclk domain
   fifo_pkg::fifo_ptr_t         rd_ptr_wr;  // wrclk domain

   fifo_wr_ctrl u_wr_ctrl (
      .wrclk(wrclk), .aclr(aclr), .wrreq(wrreq), .rd_ptr_wr(rd_ptr_wr),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_gray(wr_gray),
      .wrfull(wrfull), .wrusedw(wrusedw)
   );

   // Write pointer into the read domain
   gray_sync u_sync_wr2rd (
      .clk(rdclk), .aclr(aclr), .gray_in(wr_gray), .ptr_out(wr_ptr_rd)
   );

   // Read pointer back into the write domain
   gray_sync u_sync_rd2wr (
      .clk(wrclk), .aclr(aclr), .gray_in(rd_gray), .ptr_out(rd_ptr_wr)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .rdclk(rdclk), .aclr(aclr), .rdreq(rdreq), .wr_ptr_rd(wr_ptr_rd),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_gray(rd_gray),
      .rdempty(rdempty), .rdusedw(rdusedw), .rdvalid(rdvalid)
   );

   fifo_ram u_ram (
      .wrclk(wrclk), .rdclk(rdclk),
      .wr_en(wr_en), .wr_addr(wr_addr), .data(data),
      .rd_addr(rd_addr), .rd_en(rd_en), .q(q)
   );

endmodule

// ==== testbench/lite_fifo_asserts.sv ====
`timescale 1ns/1ps
`include "fifo_config.svh"

// Concurrent checks on the FIFO top, one clock domain each
module lite_fifo_asserts (
   input logic                  wrclk,
   input logic                  rdclk,
   input logic                  aclr,
   input logic                  rd_en,    // Accepted read inside the DUT
   input logic                  rdvalid,
   input logic                  wrfull,
   input fifo_pkg::fifo_count_t wrusedw,
   input fifo_pkg::fifo_count_t rdusedw
);

   // rdvalid only one rdclk after an accepted read
   valid_after_read: assert property (@(posedge rdclk) disable iff (aclr)
      rdvalid |-> $past(rd_en))
      else $error("rdvalid high without a read one rdclk earlier");

   wr_count_range: assert property (@(posedge wrclk) disable iff (aclr)
      wrusedw <= `FIFO_DEPTH)
      else $error("wrusedw above depth");

   rd_count_range: assert property (@(posedge rdclk) disable iff (aclr)
      rdusedw <= `FIFO_DEPTH)
      else $error("rdusedw above depth");

   // Full flag and count come from the same pointers
   full_means_depth: assert property (@(posedge wrclk) disable iff (aclr)
      wrfull |-> wrusedw >= `FIFO_DEPTH)
      else $error("wrfull high with wrusedw below depth");

endmodule

bind lite_fifo lite_fifo_asserts u_asserts (
   .wrclk(wrclk), .rdclk(rdclk), .aclr(aclr), .rd_en(rd_en), .rdvalid(rdvalid),
   .wrfull(wrfull), .wrusedw(wrusedw), .rdusedw(rdusedw)
);

// ==== testbench/tb_lite_fifo.sv ====
`timescale 1ns/1ps
`include "fifo_config.svh"

module tb_lite_fifo;

   localparam int DEPTH      = `FIFO_DEPTH;
   localparam int RD_PERIOD  = 10;
   localparam int WR_PERIOD  = 14;
   localparam int DRIVE_DLY  = 1;   // Inputs change this long after their own clock edge
   localparam int MIX_OPS    = 400;
   localparam int SETTLE_MAX = 64;  // Cycles allowed for the two domains to agree
   // Fill, drain and mixed traffic, four wrclk periods per operation
   localparam int TIMEOUT_NS = (2 * DEPTH + MIX_OPS) * WR_PERIOD * 4;

   logic                  wrclk;
   logic                  rdclk;
   logic                  aclr;
   logic                  wrreq;
   fifo_pkg::fifo_data_t  data;
   logic                  rdreq;
   logic                  wrfull;
   fifo_pkg::fifo_count_t wrusedw;
   logic                  rdempty;
   fifo_pkg::fifo_count_t rdusedw;
   logic                  rdvalid;
   fifo_pkg::fifo_data_t  q;

   fifo_pkg::fifo_data_t model [$];  // Written words still owed on q
   fifo_pkg::fifo_data_t last_q;      // Word q must hold until the next read
   logic                 have_q;      // q has loaded at least once
   logic                 read_taken;  // rdreq seen at the last rdclk edge
   int                   err_count;
   int                   check_count;
   int                   hold_checks;
   int                   hold_errs;
   int                   pushed;
   int                   popped;
   int                   errs_before;
   int                   count;

   lite_fifo u_dut (
      .wrclk(wrclk), .rdclk(rdclk), .aclr(aclr), .wrreq(wrreq), .data(data), .rdreq(rdreq),
      .wrfull(wrfull), .wrusedw(wrusedw), .rdempty(rdempty), .rdusedw(rdusedw),
      .rdvalid(rdvalid), .q(q)
   );

   initial
   begin
      rdclk = 1'b0;
      forever #(RD_PERIOD / 2) rdclk = ~rdclk;
   end

   initial
   begin
      wrclk = 1'b0;
      forever #(WR_PERIOD / 2) wrclk = ~wrclk;  // Unrelated to rdclk
   end

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_count++;
      assert (act === exp)
      else
      begin
         $display("[FAIL] %s expected %h got %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic report_test(input int num, input string name);
      $display("Test %0d %s: %s, %0d errors", num, name,
               (err_count == errs_before) ? "passed" : "failed", err_count - errs_before);
      errs_before = err_count;
   endtask

   // Write only while not full so the write is always accepted
   task automatic drive_write(input int pct);
      if (!wrfull && ($urandom % 100) < pct)
      begin
         data  = fifo_pkg::fifo_data_t'($urandom);
         wrreq = 1'b1;
         model.push_back(data);
         pushed++;
      end
      else
         wrreq = 1'b0;
   endtask

   task automatic drive_read(input int pct);
      rdreq = !rdempty && (($urandom % 100) < pct);
   endtask

   task automatic write_traffic();
      int phase;
      for (int i = 0; i < MIX_OPS; i++)
      begin
         phase = i * 3 / MIX_OPS;  // Writes faster, reads faster, balanced
         @(posedge wrclk);
         #DRIVE_DLY;
         drive_write(phase == 0 ? 80 : (phase == 1 ? 30 : 50));
      end
      @(posedge wrclk);
      #DRIVE_DLY;
      wrreq = 1'b0;
   endtask

   task automatic read_traffic();
      int phase;
      for (int i = 0; i < MIX_OPS; i++)
      begin
         phase = i * 3 / MIX_OPS;
         @(posedge rdclk);
         #DRIVE_DLY;
         drive_read(phase == 0 ? 30 : (phase == 1 ? 80 : 50));
      end
      @(posedge rdclk);
      #DRIVE_DLY;
      rdreq = 1'b0;
   endtask

   // Reads until empty, returns the number of reads issued
   task automatic drain(output int reads);
      reads = 0;
      while (!rdempty)
      begin
         drive_read(100);
         reads++;
         @(posedge rdclk);
         #DRIVE_DLY;
      end
      rdreq = 1'b0;
      @(posedge rdclk);  // Last rdvalid gets checked at the next negedge
      #DRIVE_DLY;
   endtask

   always @(posedge rdclk)
      read_taken <= rdreq && !aclr;

   // Read side monitor, samples mid cycle where the outputs are stable
   always @(negedge rdclk)
   begin
      if (!aclr)
      begin
         check_value("rdvalid", read_taken, rdvalid);
         if (rdvalid)
         begin
            assert (model.size() != 0)
            else
            begin
               $display("Word on q while the model expects nothing");
               err_count++;
            end
            if (model.size() != 0)
            begin
               last_q = model.pop_front();
               check_value("q", last_q, q);
               popped++;
               have_q = 1'b1;
            end
         end
         else if (have_q)
         begin
            hold_checks++;
            assert (q === last_q)
            else
            begin
               $display("[FAIL] q expected %h got %h while rdvalid low", last_q, q);
               hold_errs++;
               err_count++;
            end
         end
      end
   end

   initial
   begin
      void'($urandom(32'hc7a3_008f));
      aclr = 1'b1;
      wrreq = 1'b0;
      rdreq = 1'b0;
      data = '0;
      have_q = 1'b0;
      read_taken = 1'b0;
      err_count = 0;
      check_count = 0;
      hold_checks = 0;
      hold_errs = 0;
      pushed = 0;
      popped = 0;
      errs_before = 0;
      repeat (8) @(posedge rdclk);
      #DRIVE_DLY;
      aclr = 1'b0;

      check_value("rdempty", 1, rdempty);
      check_value("rdvalid", 0, rdvalid);
      check_value("wrfull", 0, wrfull);
      check_value("wrusedw", 0, wrusedw);
      check_value("rdusedw", 0, rdusedw);
      report_test(1, "reset state");

      count = 0;
      @(posedge wrclk);
      #DRIVE_DLY;
      while (!wrfull && count < 2 * DEPTH)
      begin
         drive_write(100);
         count++;
         @(posedge wrclk);
         #DRIVE_DLY;
      end
      wrreq = 1'b0;
      check_value("writes before wrfull", DEPTH, count);
      check_value("wrusedw", DEPTH, wrusedw);
      report_test(2, "fill");

      while (rdusedw != DEPTH)  // All writes visible to the read side
      begin
         @(posedge rdclk);
         #DRIVE_DLY;
      end
      drain(count);
      check_value("reads until rdempty", DEPTH, count);
      check_value("rdusedw", 0, rdusedw);
      check_value("model size", 0, model.size());
      report_test(3, "drain");

      fork
         write_traffic();
         read_traffic();
      join
      report_test(4, "mixed traffic");

      assert (hold_checks > 0)
      else
      begin
         $display("q hold was never exercised");
         err_count++;
      end
      $display("Test 5 hold between reads: %0d hold checks, %0d errors", hold_checks, hold_errs);

      @(posedge rdclk);
      #DRIVE_DLY;
      count = 0;
      while (count < SETTLE_MAX && !(rdusedw == model.size() && rdempty == (model.size() == 0)))
      begin
         @(posedge rdclk);
         #DRIVE_DLY;
         count++;
      end
      count = 0;
      while (count < SETTLE_MAX && wrusedw != model.size())
      begin
         @(posedge wrclk);
         #DRIVE_DLY;
         count++;
      end
      check_value("rdusedw", model.size(), rdusedw);
      check_value("wrusedw", model.size(), wrusedw);
      check_value("rdempty", model.size() == 0, rdempty);
      drain(count);
      check_value("words read", pushed, popped);  // Nothing lost or duplicated
      report_test(6, "final flags");

      $display("Tests run: 6, checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("Timeout: run still going after %0d ns", TIMEOUT_NS);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+hw
hw/fifo_pkg.sv
hw/gray_sync.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_ctrl.sv
hw/fifo_ram.sv
hw/lite_fifo.sv
testbench/lite_fifo_asserts.sv
testbench/tb_lite_fifo.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the lite_fifo testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lite_fifo \
   -f src.f -Mdir obj_dir -o sim_lite_fifo || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/sim_lite_fifo)"
echo "$sim_out"
echo "$sim_out" | grep -qx "No errors" && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
